//--- sj_pkg.sv
/* Shared types and constants for the main-CPU I/O board:
   register opcodes, supervisor states, bus widths and the protection table */
package sj_pkg;

	// ============================================================
	// Bus widths
	// ============================================================
	localparam int ADDR_W     = 16;           // CPU address bus
	localparam int DATA_W     = 8;            // CPU data bus
	localparam int EXT_BASE_W = 15;           // D50A[6:0] over D509[7:0]

	// CPU reset hold after a watchdog trip, in clock cycles
	localparam int RESET_HOLD_CYCLES = 4;

	// ============================================================
	// Alpine protection table
	// ============================================================
	// Each entry is {written value, latched value}. Values that are
	// not listed are latched unchanged.
	localparam int ALP_N = 6;
	localparam logic [ALP_N-1:0][2*DATA_W-1:0] ALP_ENTRIES = {
		16'h1D18,                              // 1D -> 18
		16'h1608,                              // 16 -> 08
		16'h0F00,                              // 0F -> 00
		16'h0C00,                              // 0C -> 00
		16'h0700,                              // 07 -> 00
		16'h0518                               // 05 -> 18
	};

	// ============================================================
	// Decoded register accesses
	// ============================================================
	typedef enum logic [3:0] {
		OP_NONE     = 4'd0,
		OP_EXT_LO   = 4'd1,                    // D509 write
		OP_EXT_HI   = 4'd2,                    // D50A write
		OP_EXT_RD   = 4'd3,                    // D404-D407 read
		OP_KICK     = 4'd4,                    // D50D write
		OP_COIN_SET = 4'd5,                    // D50E write
		OP_ALP_WR   = 4'd6,                    // D50F write
		OP_PROT_RD  = 4'd7,                    // D48B read
		OP_ALP_RD   = 4'd8                     // D40B read
	} sj_reg_op_t;

	// Supervisor FSM states
	typedef enum logic [1:0] {
		SUP_RUN   = 2'd0,
		SUP_INT   = 2'd1,
		SUP_RESET = 2'd2
	} sj_sup_state_t;

endpackage

//--- sj_reg_if.sv
/* Decoded register access bus between the address decoder and its users */
`timescale 1ns/1ps

interface sj_reg_if import sj_pkg::*; ();

	sj_reg_op_t        op;                     // Which register is accessed
	logic              stb;                    // One-cycle access strobe
	logic [DATA_W-1:0] wdata;                  // CPU write byte
	logic [DATA_W-1:0] rdata_ext;              // ROM reader read byte
	logic [DATA_W-1:0] rdata_prot;             // Protection read byte

	modport decoder (
		output op, stb, wdata,
		input  rdata_ext, rdata_prot
	);

	modport user (
		input  op, stb, wdata,
		output rdata_ext, rdata_prot
	);

endinterface

//--- sj_addr_decode.sv
/* CPU address decoder for the D4xx and D5xx registers, with the
   registered read data mux */
`timescale 1ns/1ps

module sj_addr_decode import sj_pkg::*; (
	input  logic              V_BLANK,
	input  logic              EXROM2,
	input  logic [ADDR_W-1:0] addr_i,
	input  logic              rd_i,
	input  logic              wr_i,
	input  logic [DATA_W-1:0] wdata_i,
	output logic [DATA_W-1:0] rdata_o,
	sj_reg_if.decoder         bus
);

	// ============================================================
	// Register map
	// ============================================================
	localparam logic [ADDR_W-1:0] ADDR_EXT_RD  = 16'hD404;   // D404-D407
	localparam logic [ADDR_W-1:0] ADDR_ALP_RD  = 16'hD40B;
	localparam logic [ADDR_W-1:0] ADDR_PROT_RD = 16'hD48B;
	localparam logic [ADDR_W-1:0] ADDR_EXT_LO  = 16'hD509;
	localparam logic [ADDR_W-1:0] ADDR_EXT_HI  = 16'hD50A;
	localparam logic [ADDR_W-1:0] ADDR_KICK    = 16'hD50D;
	localparam logic [ADDR_W-1:0] ADDR_COIN    = 16'hD50E;
	localparam logic [ADDR_W-1:0] ADDR_ALP_WR  = 16'hD50F;

	sj_reg_op_t        op_c;
	logic [DATA_W-1:0] rdata_c;

	always_comb begin
		op_c = OP_NONE;
		if (wr_i) begin
			case (addr_i)
				ADDR_EXT_LO: op_c = OP_EXT_LO;
				ADDR_EXT_HI: op_c = OP_EXT_HI;
				ADDR_KICK:   op_c = OP_KICK;
				ADDR_COIN:   op_c = OP_COIN_SET;
				ADDR_ALP_WR: op_c = OP_ALP_WR;
				default:     op_c = OP_NONE;
			endcase
		end else if (rd_i) begin
			if (addr_i[ADDR_W-1:2] == ADDR_EXT_RD[ADDR_W-1:2])
				op_c = OP_EXT_RD;              // Any of the four ROM ports
			else if (addr_i == ADDR_PROT_RD)
				op_c = OP_PROT_RD;
			else if (addr_i == ADDR_ALP_RD)
				op_c = OP_ALP_RD;
		end
	end

	assign bus.op    = op_c;
	assign bus.stb   = rd_i | wr_i;
	assign bus.wdata = wdata_i;

	// Read data source
	always_comb begin
		case (op_c)
			OP_EXT_RD:             rdata_c = bus.rdata_ext;
			OP_PROT_RD, OP_ALP_RD: rdata_c = bus.rdata_prot;
			default:               rdata_c = '0;   // Unmapped reads give 00
		endcase
	end

	always_ff @(posedge V_BLANK or negedge EXROM2) begin
		if (!EXROM2)
			rdata_o <= '0;
		else if (rd_i)
			rdata_o <= rdata_c;                // Valid the cycle after rd_i
	end

	a_rd_wr_excl: assert property (@(posedge V_BLANK) disable iff (!EXROM2)
		!(rd_i && wr_i));

endmodule

//--- sj_ext_rom_reader.sv
/* External graphics ROM board: D509/D50A base latches, auto-incrementing
   offset counter and the ROM itself */
`timescale 1ns/1ps

module sj_ext_rom_reader import sj_pkg::*; #(
	parameter int EXT_ROM_AW = 5
) (
	input  logic V_BLANK,
	input  logic EXROM2,
	sj_reg_if.user bus
);

	logic [DATA_W-1:0]       rom [2**EXT_ROM_AW];
	logic [7:0]              base_lo;          // D509
	logic [EXT_BASE_W-9:0]   base_hi;          // D50A[6:0]
	logic [EXT_BASE_W-1:0]   offset;
	logic [EXT_BASE_W-1:0]   ext_addr;
	logic                    offset_touch;

	initial begin
		$readmemh("ext_rom.hex", rom);
	end

	// ============================================================
	// Base latches and offset counter
	// ============================================================
	always_ff @(posedge V_BLANK or negedge EXROM2) begin
		if (!EXROM2) begin
			base_lo <= '0;
			base_hi <= '0;
			offset  <= '0;
		end else if (bus.stb) begin
			case (bus.op)
				OP_EXT_LO: base_lo <= bus.wdata;
				OP_EXT_HI: begin
					base_hi <= bus.wdata[EXT_BASE_W-9:0];
					offset  <= '0;                 // High write restarts the count
				end
				OP_EXT_RD: offset <= offset + EXT_BASE_W'(1);
				default: ;
			endcase
		end
	end

	assign ext_addr = {base_hi, base_lo} + offset;

	// Byte at the current offset, wraps within the ROM
	assign bus.rdata_ext = rom[ext_addr[EXT_ROM_AW-1:0]];

	assign offset_touch = bus.stb && (bus.op == OP_EXT_RD || bus.op == OP_EXT_HI);

	a_offset_stable: assert property (@(posedge V_BLANK) disable iff (!EXROM2)
		!offset_touch |=> $stable(offset));

endmodule

//--- sj_game_latches.sv
/* Coin and bank control latch at D50E plus the D48B toggle and
   D50F lookup protection registers */
`timescale 1ns/1ps

module sj_game_latches import sj_pkg::*; (
	input  logic   V_BLANK,
	input  logic   EXROM2,
	sj_reg_if.user bus,
	output logic   bank_sel_o,
	output logic   sound_stop_o,
	output logic   coin_lock_o
);

	logic [DATA_W-1:0] prot_q;                 // Space Cruiser toggle byte
	logic [DATA_W-1:0] alp_q;                  // Alpine table byte
	logic [DATA_W-1:0] alp_next;

	// Table lookup, unknown values pass through
	always_comb begin
		alp_next = bus.wdata;
		for (int i = 0; i < ALP_N; i++) begin
			if (bus.wdata == ALP_ENTRIES[i][2*DATA_W-1:DATA_W])
				alp_next = ALP_ENTRIES[i][DATA_W-1:0];
		end
	end

	always_ff @(posedge V_BLANK or negedge EXROM2) begin
		if (!EXROM2) begin
			bank_sel_o   <= 1'b0;
			sound_stop_o <= 1'b0;
			coin_lock_o  <= 1'b0;
			prot_q       <= '0;
			alp_q        <= '0;
		end else if (bus.stb) begin
			case (bus.op)
				OP_COIN_SET: begin
					bank_sel_o   <= bus.wdata[7];
					sound_stop_o <= bus.wdata[1];
					coin_lock_o  <= bus.wdata[0];
				end
				OP_PROT_RD: prot_q <= ~prot_q;  // Flips on every read
				OP_ALP_WR:  alp_q  <= alp_next;
				default: ;
			endcase
		end
	end

	// A toggle read returns the byte after inversion
	assign bus.rdata_prot = (bus.op == OP_PROT_RD) ? ~prot_q : alp_q;

endmodule

//--- sj_frame_timer.sv
/* Vertical blank edge detector and the frame-counting watchdog */
`timescale 1ns/1ps

module sj_frame_timer import sj_pkg::*; #(
	parameter int WD_FRAMES = 128
) (
	input  logic   V_BLANK,
	input  logic   EXROM2,
	input  logic   vbl_i,
	sj_reg_if.user bus,
	output logic   frame_tick_o,
	output logic   wd_expire_o
);

	localparam int CNT_W = (WD_FRAMES > 1) ? $clog2(WD_FRAMES) : 1;

	logic             vbl_q;
	logic [CNT_W-1:0] frame_cnt;
	logic             kick;
	logic             last_frame;

	assign kick       = bus.stb && (bus.op == OP_KICK);
	assign last_frame = (frame_cnt == CNT_W'(WD_FRAMES - 1));

	always_ff @(posedge V_BLANK or negedge EXROM2) begin
		if (!EXROM2) begin
			vbl_q        <= 1'b0;
			frame_tick_o <= 1'b0;
			frame_cnt    <= '0;
		end else begin
			vbl_q        <= vbl_i;
			frame_tick_o <= vbl_i & ~vbl_q;     // One cycle after the rise
			if (kick)
				frame_cnt <= '0;
			else if (frame_tick_o)
				frame_cnt <= last_frame ? '0 : frame_cnt + CNT_W'(1);
		end
	end

	// Trips on the frame that completes the count
	assign wd_expire_o = frame_tick_o && last_frame && !kick;

endmodule

//--- sj_supervisor_fsm.sv
/* Supervisor FSM for the frame interrupt and the CPU reset hold */
`timescale 1ns/1ps

module sj_supervisor_fsm import sj_pkg::*; (
	input  logic V_BLANK,
	input  logic EXROM2,
	input  logic frame_tick_i,
	input  logic wd_expire_i,
	input  logic int_ack_i,
	output logic int_n_o,
	output logic cpu_reset_n_o
);

	localparam int HOLD_W = (RESET_HOLD_CYCLES > 1) ? $clog2(RESET_HOLD_CYCLES) : 1;

	sj_sup_state_t     state;
	logic [HOLD_W-1:0] hold_cnt;

	// ============================================================
	// State register
	// ============================================================
	always_ff @(posedge V_BLANK or negedge EXROM2) begin
		if (!EXROM2) begin
			state    <= SUP_RUN;
			hold_cnt <= '0;
		end else if (wd_expire_i) begin
			state    <= SUP_RESET;             // Watchdog wins from any state
			hold_cnt <= '0;
		end else begin
			case (state)
				SUP_RUN: begin
					if (frame_tick_i)
						state <= SUP_INT;
				end
				SUP_INT: begin
					if (int_ack_i)
						state <= SUP_RUN;
				end
				SUP_RESET: begin
					if (hold_cnt == HOLD_W'(RESET_HOLD_CYCLES - 1))
						state <= SUP_RUN;
					else
						hold_cnt <= hold_cnt + HOLD_W'(1);
				end
				default: state <= SUP_RUN;
			endcase
		end
	end

	// Outputs decoded from state, frame ticks ignored in reset
	assign int_n_o       = (state != SUP_INT);
	assign cpu_reset_n_o = (state != SUP_RESET);

	a_not_both_low: assert property (@(posedge V_BLANK) disable iff (!EXROM2)
		int_n_o || cpu_reset_n_o);

	// Reset released only after exactly the hold time
	a_reset_hold: assert property (@(posedge V_BLANK) disable iff (!EXROM2)
		$rose(cpu_reset_n_o) |->
			$past(!cpu_reset_n_o, RESET_HOLD_CYCLES) &&
			$past(cpu_reset_n_o, RESET_HOLD_CYCLES + 1));

endmodule

//--- sj_io_board.sv
/* Main-CPU I/O board top level: decoder, ROM reader, game latches,
   frame timer and supervisor */
`timescale 1ns/1ps

module sj_io_board import sj_pkg::*; #(
	parameter int EXT_ROM_AW = 5,
	parameter int WD_FRAMES  = 128
) (
	input  logic              V_BLANK,
	input  logic              EXROM2,
	input  logic [ADDR_W-1:0] addr_i,
	input  logic [DATA_W-1:0] wdata_i,
	input  logic              rd_i,
	input  logic              wr_i,
	input  logic              vbl_i,
	input  logic              int_ack_i,
	output logic [DATA_W-1:0] rdata_o,
	output logic              int_n_o,
	output logic              cpu_reset_n_o,
	output logic              bank_sel_o,
	output logic              sound_stop_o,
	output logic              coin_lock_o
);

	sj_reg_if bus ();

	logic frame_tick;
	logic wd_expire;

	// ============================================================
	// CPU side
	// ============================================================
	sj_addr_decode u_decode (
		.V_BLANK (V_BLANK),
		.EXROM2  (EXROM2),
		.addr_i  (addr_i),
		.rd_i    (rd_i),
		.wr_i    (wr_i),
		.wdata_i (wdata_i),
		.rdata_o (rdata_o),
		.bus     (bus.decoder)
	);

	sj_ext_rom_reader #(
		.EXT_ROM_AW (EXT_ROM_AW)
	) u_ext_rom (
		.V_BLANK (V_BLANK),
		.EXROM2  (EXROM2),
		.bus     (bus.user)
	);

	sj_game_latches u_latches (
		.V_BLANK      (V_BLANK),
		.EXROM2       (EXROM2),
		.bus          (bus.user),
		.bank_sel_o   (bank_sel_o),
		.sound_stop_o (sound_stop_o),
		.coin_lock_o  (coin_lock_o)
	);

	// ============================================================
	// Frame timing and supervision
	// ============================================================
	sj_frame_timer #(
		.WD_FRAMES (WD_FRAMES)
	) u_frame_timer (
		.V_BLANK      (V_BLANK),
		.EXROM2       (EXROM2),
		.vbl_i        (vbl_i),
		.bus          (bus.user),
		.frame_tick_o (frame_tick),
		.wd_expire_o  (wd_expire)
	);

	sj_supervisor_fsm u_supervisor (
		.V_BLANK       (V_BLANK),
		.EXROM2        (EXROM2),
		.frame_tick_i  (frame_tick),
		.wd_expire_i   (wd_expire),
		.int_ack_i     (int_ack_i),
		.int_n_o       (int_n_o),
		.cpu_reset_n_o (cpu_reset_n_o)
	);

endmodule

//--- tb_sj_io_board.sv
/* Directed testbench for the I/O board: ROM reader, coin latch, protection,
   frame interrupt and watchdog */
`timescale 1ns/1ps

module tb_sj_io_board;

	localparam int CLK_PERIOD  = 4;
	localparam int TEST_CYCLES = 10 + 60 + 25 + 40 + 30 + 110 + 90;   // Per-test budgets
	localparam int TIMEOUT_NS  = 2 * TEST_CYCLES * CLK_PERIOD;

	logic        V_BLANK   = 1'b0;
	logic        EXROM2    = 1'b0;
	logic [15:0] addr_i    = 16'h0000;
	logic [7:0]  wdata_i   = 8'h00;
	logic        rd_i      = 1'b0;
	logic        wr_i      = 1'b0;
	logic        vbl_i     = 1'b0;
	logic        int_ack_i = 1'b0;
	logic [7:0]  rdata_o;
	logic        int_n_o;
	logic        cpu_reset_n_o;
	logic        bank_sel_o;
	logic        sound_stop_o;
	logic        coin_lock_o;

	logic [7:0]  rom_ref [32];
	logic [7:0]  alp_key [6] = '{8'h05, 8'h07, 8'h0C, 8'h0F, 8'h16, 8'h1D};
	logic [7:0]  alp_val [6] = '{8'h18, 8'h00, 8'h00, 8'h00, 8'h08, 8'h18};
	logic [7:0]  m_lo = 8'h00;                 // Model of the ROM base and offset
	logic [6:0]  m_hi = 7'h00;
	int          m_offset = 0;
	integer      seed = 70;
	int          error_count = 0;

	sj_io_board #(
		.WD_FRAMES (8)
	) sj_io_board_i (
		.V_BLANK       (V_BLANK),
		.EXROM2        (EXROM2),
		.addr_i        (addr_i),
		.wdata_i       (wdata_i),
		.rd_i          (rd_i),
		.wr_i          (wr_i),
		.vbl_i         (vbl_i),
		.int_ack_i     (int_ack_i),
		.rdata_o       (rdata_o),
		.int_n_o       (int_n_o),
		.cpu_reset_n_o (cpu_reset_n_o),
		.bank_sel_o    (bank_sel_o),
		.sound_stop_o  (sound_stop_o),
		.coin_lock_o   (coin_lock_o)
	);

	always #(CLK_PERIOD / 2) V_BLANK = ~V_BLANK;

	// ============================================================
	// Helpers
	// ============================================================
	task automatic abort_run(input string what);
		$display("%s", what);
		$display("Testbench failed");
		$fatal(1, "Run stopped");
	endtask

	task automatic check_value(input string name, input logic [7:0] got,
	                           input logic [7:0] expected);
		if (got !== expected) begin
			$display("ERROR at %0t ns: %s is 0x%02h, expected 0x%02h",
			         $time, name, got, expected);
			error_count++;
			abort_run("Stopping at the first mismatch");
		end
	endtask

	task automatic tick();
		@(posedge V_BLANK);
		#1;                                    // Drive and sample past the edge
	endtask

	task automatic bus_write(input logic [15:0] a, input logic [7:0] d);
		addr_i  = a;
		wdata_i = d;
		wr_i    = 1'b1;
		tick();
		wr_i    = 1'b0;
	endtask

	task automatic bus_read(input logic [15:0] a, output logic [7:0] d);
		addr_i = a;
		rd_i   = 1'b1;
		tick();
		rd_i   = 1'b0;
		d      = rdata_o;                      // Registered one cycle after rd_i
	endtask

	function automatic logic [7:0] alp_map(input logic [7:0] v);
		logic [7:0] r;
		r = v;
		for (int i = 0; i < 6; i++) begin
			if (v == alp_key[i])
				r = alp_val[i];
		end
		return r;
	endfunction

	function automatic logic is_mapped_read(input logic [15:0] a);
		return (a >= 16'hD404 && a <= 16'hD407) || a == 16'hD40B || a == 16'hD48B;
	endfunction

	task automatic set_base_lo(input logic [7:0] v);
		bus_write(16'hD509, v);
		m_lo = v;
	endtask

	task automatic set_base_hi(input logic [7:0] v);
		bus_write(16'hD50A, v);
		m_hi     = v[6:0];
		m_offset = 0;                          // High write restarts the count
	endtask

	// Back-to-back reads through the four ROM ports
	task automatic read_rom_burst(input int n);
		logic [4:0] idx;
		rd_i = 1'b1;
		for (int i = 0; i < n; i++) begin
			addr_i = 16'hD404 + 16'(i % 4);
			idx    = 5'({m_hi, m_lo} + 15'(m_offset));
			tick();
			check_value("rdata_o", rdata_o, rom_ref[idx]);
			m_offset++;
		end
		rd_i = 1'b0;
	endtask

	task automatic run_frame();
		vbl_i = 1'b1;
		tick();
		check_value("int_n_o", 8'(int_n_o), 8'd1);
		tick();
		check_value("int_n_o", 8'(int_n_o), 8'd0);
		vbl_i     = 1'b0;
		int_ack_i = 1'b1;
		tick();
		int_ack_i = 1'b0;
		check_value("int_n_o", 8'(int_n_o), 8'd1);
		repeat (4) begin
			tick();
			check_value("cpu_reset_n_o", 8'(cpu_reset_n_o), 8'd1);
		end
	endtask

	// ============================================================
	// Tests
	// ============================================================
	task automatic test_reset_values();
		check_value("int_n_o", 8'(int_n_o), 8'd1);
		check_value("cpu_reset_n_o", 8'(cpu_reset_n_o), 8'd1);
		check_value("rdata_o", rdata_o, 8'h00);
		check_value("bank_sel_o", 8'(bank_sel_o), 8'd0);
		check_value("sound_stop_o", 8'(sound_stop_o), 8'd0);
		check_value("coin_lock_o", 8'(coin_lock_o), 8'd0);
		read_rom_burst(2);                     // Base and offset start at zero
	endtask

	task automatic test_ext_rom();
		for (int r = 0; r < 3; r++) begin
			set_base_lo(8'($random(seed)));
			set_base_hi(8'($random(seed)));
			read_rom_burst(5);
			set_base_lo(8'($random(seed)));    // Count carries on
			read_rom_burst(3);
			set_base_hi(8'($random(seed)));
			read_rom_burst(4);
		end
	endtask

	task automatic test_coin_latch();
		logic [7:0] v;
		repeat (10) begin
			v = 8'($random(seed));
			bus_write(16'hD50E, v);
			check_value("bank_sel_o", 8'(bank_sel_o), 8'(v[7]));
			check_value("sound_stop_o", 8'(sound_stop_o), 8'(v[1]));
			check_value("coin_lock_o", 8'(coin_lock_o), 8'(v[0]));
		end
	endtask

	task automatic test_protection();
		logic [7:0] d;
		logic [7:0] v;
		bus_read(16'hD40B, d);
		check_value("rdata_o", d, 8'h00);
		for (int i = 0; i < 6; i++) begin
			bus_read(16'hD48B, d);
			check_value("rdata_o", d, (i % 2 == 0) ? 8'hFF : 8'h00);
		end
		for (int i = 0; i < 6; i++) begin
			bus_write(16'hD50F, alp_key[i]);
			bus_read(16'hD40B, d);
			check_value("rdata_o", d, alp_val[i]);
		end
		repeat (6) begin
			v = 8'($random(seed));
			bus_write(16'hD50F, v);
			bus_read(16'hD40B, d);
			check_value("rdata_o", d, alp_map(v));
		end
	endtask

	task automatic test_frame_interrupt();
		logic [15:0] a;
		logic [7:0]  d;
		bus_write(16'hD50D, 8'h00);            // Kick before counting frames
		vbl_i = 1'b1;
		tick();
		check_value("int_n_o", 8'(int_n_o), 8'd1);
		tick();
		check_value("int_n_o", 8'(int_n_o), 8'd0);
		vbl_i = 1'b0;
		repeat (4) begin
			a = 16'($random(seed));
			if (is_mapped_read(a))
				a = 16'hD400;
			bus_read(a, d);
			check_value("rdata_o", d, 8'h00);
			check_value("int_n_o", 8'(int_n_o), 8'd0);
		end
		int_ack_i = 1'b1;
		tick();
		int_ack_i = 1'b0;
		check_value("int_n_o", 8'(int_n_o), 8'd1);
	endtask

	task automatic test_watchdog_kick();
		for (int f = 0; f < 12; f++) begin
			if (f % 3 == 0)
				bus_write(16'hD50D, 8'($random(seed)));
			run_frame();
		end
	endtask

	task automatic test_watchdog_expiry();
		int wait_cycles;
		int low_cycles;
		wait_cycles = 0;
		low_cycles  = 0;
		bus_write(16'hD50D, 8'h00);
		repeat (7) run_frame();
		vbl_i = 1'b1;                          // Eighth frame without a kick
		tick();
		vbl_i = 1'b0;
		while (cpu_reset_n_o && wait_cycles < 4) begin
			tick();
			wait_cycles++;
		end
		if (cpu_reset_n_o)
			abort_run("cpu_reset_n_o never fell after eight frames without a kick");
		while (!cpu_reset_n_o && low_cycles < 10) begin
			check_value("int_n_o", 8'(int_n_o), 8'd1);
			vbl_i = (low_cycles == 0);         // Frame edge inside the hold
			low_cycles++;
			tick();
		end
		check_value("reset hold cycles", 8'(low_cycles), 8'd4);
		check_value("int_n_o", 8'(int_n_o), 8'd1);
		run_frame();                           // Board runs again after the hold
	endtask

	// ============================================================
	// Main sequence and timeout
	// ============================================================
	initial begin
		$readmemh("ext_rom.hex", rom_ref);
		repeat (5) @(posedge V_BLANK);
		#1;
		EXROM2 = 1'b1;
		tick();
		test_reset_values();
		test_ext_rom();
		test_coin_latch();
		test_protection();
		test_frame_interrupt();
		test_watchdog_kick();
		test_watchdog_expiry();
		if (error_count == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

	initial begin
		#(TIMEOUT_NS);
		abort_run("Simulation timed out before all tests finished");
	end

endmodule

//--- ext_rom.hex
// External graphics ROM, one data byte per line, addresses 00 to 1F in order
47
64
81
9E
BB
D8
F5
12
2F
4C
69
86
A3
C0
DD
FA
17
34
51
6E
8B
A8
C5
E2
FF
1C
39
56
73
90
AD
CA

//--- list.f
sj_pkg.sv
sj_reg_if.sv
sj_addr_decode.sv
sj_ext_rom_reader.sv
sj_game_latches.sv
sj_frame_timer.sv
sj_supervisor_fsm.sv
sj_io_board.sv
tb_sj_io_board.sv

//--- Makefile
TOP = tb_sj_io_board

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f list.f -o $(TOP)

run: build
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -q "^Testbench passed$$"

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f list.f

clean:
	rm -rf obj_dir
